/* sim.f */
src/dcache_geom_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_req_port.sv
src/dcache_tag_store.sv
src/dcache_data_store.sv
src/dcache_ctrl.sv
src/dcache_mem_port.sv
src/dcache_top.sv
verification/dcache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f sim.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

/* verification/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam int NUM_REQ = 1500;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 24;
    localparam logic [31:0] SEED = 32'd33031;

    logic                     clk;
    logic                     rst_n_i;
    logic                     req_read_i;
    logic                     req_write_i;
    dcache_geom_pkg::addr_t   req_addr_i;
    dcache_geom_pkg::word_t   req_wdata_i;
    dcache_geom_pkg::strb_t   req_strb_i;
    logic                     busy_o;
    logic                     done_o;
    dcache_geom_pkg::word_t   rsp_rdata_o;
    dcache_ctrl_pkg::mem_op_t mem_op_o;
    dcache_geom_pkg::addr_t   mem_addr_o;
    dcache_geom_pkg::word_t   mem_wdata_o;
    logic                     mem_ready_i;
    dcache_geom_pkg::word_t   mem_rdata_i;

    int          errors;
    logic [31:0] rng_req;
    logic [31:0] rng_mem;

    // golden contents and the memory behind the cache, keyed by line address
    dcache_geom_pkg::word_t golden_mem [dcache_geom_pkg::addr_t];
    dcache_geom_pkg::word_t backing_mem [dcache_geom_pkg::addr_t];

    // shadow of the tag store
    dcache_geom_pkg::tag_t sh_tag [dcache_geom_pkg::SETS][dcache_geom_pkg::WAYS];
    logic sh_valid [dcache_geom_pkg::SETS][dcache_geom_pkg::WAYS];
    logic sh_dirty [dcache_geom_pkg::SETS][dcache_geom_pkg::WAYS];
    logic sh_lru [dcache_geom_pkg::SETS];

    // memory operations seen during the current request
    dcache_ctrl_pkg::mem_op_t op_kind_q [$];
    dcache_geom_pkg::addr_t   op_addr_q [$];
    dcache_geom_pkg::word_t   op_data_q [$];

    dcache_top dcache_top_inst (
        .clk, .rst_n_i, .req_read_i, .req_write_i, .req_addr_i, .req_wdata_i, .req_strb_i,
        .busy_o, .done_o, .rsp_rdata_o, .mem_op_o, .mem_addr_o, .mem_wdata_o,
        .mem_ready_i, .mem_rdata_i
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic dcache_geom_pkg::word_t fill_word(input dcache_geom_pkg::addr_t a);
        return {a ^ 32'h5a5a_1234, ~a};
    endfunction

    function automatic dcache_geom_pkg::word_t golden_read(input dcache_geom_pkg::addr_t a);
        if (golden_mem.exists(a)) begin
            return golden_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic dcache_geom_pkg::word_t backing_read(input dcache_geom_pkg::addr_t a);
        if (backing_mem.exists(a)) begin
            return backing_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic dcache_geom_pkg::mask_t expand_strobes(input dcache_geom_pkg::strb_t s);
        dcache_geom_pkg::mask_t m;
        for (int b = 0; b < dcache_geom_pkg::STRB_W; b++) begin
            m[b*8 +: 8] = s[b] ? 8'hff : 8'h00;
        end
        return m;
    endfunction

    // 4 tags by 4 sets keeps conflicts frequent
    function automatic dcache_geom_pkg::addr_t pick_addr(input logic [31:0] r);
        dcache_geom_pkg::tag_t   t;
        dcache_geom_pkg::index_t i;
        case (r[1:0])
            2'd0: t = 23'h000010;
            2'd1: t = 23'h1a2b3c;
            2'd2: t = 23'h7fffff;
            default: t = 23'h055aa5;
        endcase
        case (r[3:2])
            2'd0: i = 6'd0;
            2'd1: i = 6'd5;
            2'd2: i = 6'd37;
            default: i = 6'd63;
        endcase
        return {t, i, r[6:4]};
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic issue_request(input logic is_write, input dcache_geom_pkg::addr_t addr,
                                 input dcache_geom_pkg::word_t wdata,
                                 input dcache_geom_pkg::strb_t strb);
        dcache_geom_pkg::tag_t   t;
        dcache_geom_pkg::index_t idx;
        dcache_geom_pkg::addr_t  line;
        dcache_geom_pkg::addr_t  wb_line;
        dcache_geom_pkg::word_t  expect_rd;
        dcache_geom_pkg::mask_t  mask;
        logic                    hit;
        logic                    wb;
        int                      way;
        int                      n;
        int                      w;
        t = addr[31:9];
        idx = addr[8:3];
        line = {addr[31:3], 3'b000};
        hit = 1'b0;
        way = 0;
        for (w = 0; w < dcache_geom_pkg::WAYS; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        // miss takes an invalid way first, way 0 first, else the lru way
        if (!hit) begin
            if (!sh_valid[idx][0]) begin
                way = 0;
            end else if (!sh_valid[idx][1]) begin
                way = 1;
            end else begin
                way = int'(sh_lru[idx]);
            end
        end
        wb = !hit && sh_valid[idx][way] && sh_dirty[idx][way];
        wb_line = {sh_tag[idx][way], idx, {dcache_geom_pkg::OFFSET_W{1'b0}}};
        expect_rd = golden_read(line);
        mask = expand_strobes(strb);

        @(posedge clk);
        req_read_i <= !is_write;
        req_write_i <= is_write;
        req_addr_i <= addr;
        req_wdata_i <= wdata;
        req_strb_i <= strb;
        @(posedge clk);
        req_read_i <= 1'b0;
        req_write_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (!done_o) begin
                check_value("busy during request", 64'(busy_o), 64'd1);
            end
        end while (!done_o);

        if (!is_write) begin
            check_value("read data", rsp_rdata_o, expect_rd);
        end
        if (hit) begin
            // done in the cycle after the second edge past acceptance
            check_value("hit latency", 64'(n), 64'd3);
            check_value("memory operations on hit", 64'(op_kind_q.size()), 64'd0);
        end else begin
            check_value("memory operations on miss", 64'(op_kind_q.size()),
                        wb ? 64'd2 : 64'd1);
            if (op_kind_q.size() == (wb ? 2 : 1)) begin
                if (wb) begin
                    check_value("writeback op", 64'(op_kind_q.pop_front()),
                                64'(dcache_ctrl_pkg::MEM_WRITEBACK));
                    check_value("writeback address", 64'(op_addr_q.pop_front()), 64'(wb_line));
                    check_value("writeback data", op_data_q.pop_front(), golden_read(wb_line));
                end
                check_value("refill op", 64'(op_kind_q.pop_front()),
                            64'(dcache_ctrl_pkg::MEM_REFILL));
                check_value("refill address", 64'(op_addr_q.pop_front()), 64'(line));
            end
        end
        op_kind_q.delete();
        op_addr_q.delete();
        op_data_q.delete();

        if (!hit) begin
            sh_tag[idx][way] = t;
            sh_valid[idx][way] = 1'b1;
            sh_dirty[idx][way] = 1'b0;
        end
        if (is_write) begin
            sh_dirty[idx][way] = 1'b1;
            golden_mem[line] = (expect_rd & ~mask) | (wdata & mask);
        end
        sh_lru[idx] = (way == 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : mem_responder
        int                       delay;
        dcache_ctrl_pkg::mem_op_t op;
        dcache_geom_pkg::addr_t   a;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (rst_n_i && mem_op_o != dcache_ctrl_pkg::MEM_NONE) begin
                op = mem_op_o;
                a = mem_addr_o;
                op_kind_q.push_back(op);
                op_addr_q.push_back(a);
                op_data_q.push_back(mem_wdata_o);
                rng_mem = xorshift32(rng_mem);
                delay = 1 + int'(rng_mem[1:0]);
                repeat (delay) @(posedge clk);
                mem_ready_i <= 1'b1;
                if (op == dcache_ctrl_pkg::MEM_WRITEBACK) begin
                    backing_mem[a] = mem_wdata_o;
                end else begin
                    mem_rdata_i <= backing_read(a);
                end
                @(posedge clk);
                mem_ready_i <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: requests did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d", errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int          k;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        errors = 0;
        rng_req = SEED;
        rng_mem = xorshift32(SEED);
        rst_n_i = 1'b0;
        req_read_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i = '0;
        req_wdata_i = '0;
        req_strb_i = '0;
        for (int s = 0; s < dcache_geom_pkg::SETS; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < dcache_geom_pkg::WAYS; w++) begin
                sh_tag[s][w] = '0;
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("busy after reset", 64'(busy_o), 64'd0);
        check_value("done after reset", 64'(done_o), 64'd0);
        check_value("memory op after reset", 64'(mem_op_o), 64'(dcache_ctrl_pkg::MEM_NONE));

        for (k = 0; k < NUM_REQ; k++) begin
            rng_req = xorshift32(rng_req);
            r0 = rng_req;
            rng_req = xorshift32(rng_req);
            r1 = rng_req;
            rng_req = xorshift32(rng_req);
            r2 = rng_req;
            issue_request(r0[7], pick_addr(r0), {r1, r2}, r0[15:8]);
        end

        $display("errors: %0d over %0d requests", errors, NUM_REQ);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     req_read_i,
    input  logic                     req_write_i,
    input  dcache_geom_pkg::addr_t   req_addr_i,
    input  dcache_geom_pkg::word_t   req_wdata_i,
    input  dcache_geom_pkg::strb_t   req_strb_i,
    output logic                     busy_o,
    output logic                     done_o,
    output dcache_geom_pkg::word_t   rsp_rdata_o,
    output dcache_ctrl_pkg::mem_op_t mem_op_o,
    output dcache_geom_pkg::addr_t   mem_addr_o,
    output dcache_geom_pkg::word_t   mem_wdata_o,
    input  logic                     mem_ready_i,
    input  dcache_geom_pkg::word_t   mem_rdata_i
);

    logic                    start, is_write, idle, hit, victim_dirty, mem_done;
    logic                    wr_en, wr_sel_refill, fill, mark_dirty, touch;
    logic                    wb_start, refill_start;
    dcache_geom_pkg::tag_t   tag, victim_tag;
    dcache_geom_pkg::index_t index;
    dcache_geom_pkg::word_t  wdata, refill_word, rd_data, wr_data;
    dcache_geom_pkg::mask_t  wmask, wr_mask;
    dcache_geom_pkg::way_t   hit_way, victim_way, rd_way, wr_way;

    // refill writes the whole word
    assign wr_data     = wr_sel_refill ? refill_word : wdata;
    assign wr_mask     = wr_sel_refill ? '1 : wmask;
    assign rsp_rdata_o = rd_data;

    dcache_req_port dcache_req_port_inst (
        .clk, .rst_n_i, .req_read_i, .req_write_i, .req_addr_i, .req_wdata_i, .req_strb_i,
        .idle_i(idle), .start_o(start), .is_write_o(is_write), .tag_o(tag),
        .index_o(index), .wdata_o(wdata), .wmask_o(wmask)
    );

    dcache_tag_store dcache_tag_store_inst (
        .clk, .rst_n_i, .index_i(index), .tag_i(tag), .hit_o(hit), .hit_way_o(hit_way),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag),
        .fill_i(fill), .fill_way_i(wr_way), .mark_dirty_i(mark_dirty), .touch_i(touch),
        .touch_way_i(wr_way)
    );

    dcache_data_store dcache_data_store_inst (
        .clk, .index_i(index), .rd_way_i(rd_way), .rd_data_o(rd_data), .wr_en_i(wr_en),
        .wr_way_i(wr_way), .wr_data_i(wr_data), .wr_mask_i(wr_mask)
    );

    dcache_ctrl dcache_ctrl_inst (
        .clk, .rst_n_i, .start_i(start), .is_write_i(is_write), .hit_i(hit),
        .hit_way_i(hit_way), .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .mem_done_i(mem_done), .idle_o(idle), .busy_o, .done_o, .rd_way_o(rd_way),
        .wr_en_o(wr_en), .wr_way_o(wr_way), .wr_sel_refill_o(wr_sel_refill), .fill_o(fill),
        .mark_dirty_o(mark_dirty), .touch_o(touch), .wb_start_o(wb_start),
        .refill_start_o(refill_start)
    );

    dcache_mem_port dcache_mem_port_inst (
        .clk, .rst_n_i, .wb_start_i(wb_start), .refill_start_i(refill_start), .tag_i(tag),
        .victim_tag_i(victim_tag), .index_i(index), .victim_data_i(rd_data), .mem_op_o,
        .mem_addr_o, .mem_wdata_o, .mem_ready_i, .mem_rdata_i, .mem_done_o(mem_done),
        .refill_word_o(refill_word)
    );

endmodule

/* src/dcache_mem_port.sv */
`timescale 1ns/1ps

module dcache_mem_port (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     wb_start_i,
    input  logic                     refill_start_i,
    input  dcache_geom_pkg::tag_t    tag_i,
    input  dcache_geom_pkg::tag_t    victim_tag_i,
    input  dcache_geom_pkg::index_t  index_i,
    input  dcache_geom_pkg::word_t   victim_data_i,
    output dcache_ctrl_pkg::mem_op_t mem_op_o,
    output dcache_geom_pkg::addr_t   mem_addr_o,
    output dcache_geom_pkg::word_t   mem_wdata_o,
    input  logic                     mem_ready_i,
    input  dcache_geom_pkg::word_t   mem_rdata_i,
    output logic                     mem_done_o,
    output dcache_geom_pkg::word_t   refill_word_o
);

    logic ack;

    assign ack = (mem_op_o != dcache_ctrl_pkg::MEM_NONE) && mem_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_op_o   <= dcache_ctrl_pkg::MEM_NONE;
            mem_done_o <= 1'b0;
        end else begin
            mem_done_o <= ack;
            if (ack) begin
                mem_op_o <= dcache_ctrl_pkg::MEM_NONE;
            end else if (wb_start_i) begin
                mem_op_o <= dcache_ctrl_pkg::MEM_WRITEBACK;
            end else if (refill_start_i) begin
                mem_op_o <= dcache_ctrl_pkg::MEM_REFILL;
            end
        end
    end

    // word aligned, victim line for writeback, request line for refill
    always_ff @(posedge clk) begin
        if (wb_start_i) begin
            mem_addr_o  <= {victim_tag_i, index_i, {dcache_geom_pkg::OFFSET_W{1'b0}}};
            mem_wdata_o <= victim_data_i;
        end else if (refill_start_i) begin
            mem_addr_o <= {tag_i, index_i, {dcache_geom_pkg::OFFSET_W{1'b0}}};
        end
        if (ack && (mem_op_o == dcache_ctrl_pkg::MEM_REFILL)) begin
            refill_word_o <= mem_rdata_i;
        end
    end

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  is_write_i,
    input  logic                  hit_i,
    input  dcache_geom_pkg::way_t hit_way_i,
    input  dcache_geom_pkg::way_t victim_way_i,
    input  logic                  victim_dirty_i,
    input  logic                  mem_done_i,
    output logic                  idle_o,
    output logic                  busy_o,
    output logic                  done_o,
    output dcache_geom_pkg::way_t rd_way_o,
    output logic                  wr_en_o,
    output dcache_geom_pkg::way_t wr_way_o,
    output logic                  wr_sel_refill_o,
    output logic                  fill_o,
    output logic                  mark_dirty_o,
    output logic                  touch_o,
    output logic                  wb_start_o,
    output logic                  refill_start_o
);

    dcache_ctrl_pkg::ctrl_state_t state_q;
    dcache_ctrl_pkg::ctrl_state_t state_d;
    // hit way or victim way, chosen in lookup
    dcache_geom_pkg::way_t        way_q;
    // memory operation already issued in this state
    logic                         issued_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_ctrl_pkg::IDLE: begin
                if (start_i) begin
                    state_d = dcache_ctrl_pkg::LOOKUP;
                end
            end
            dcache_ctrl_pkg::LOOKUP: begin
                if (hit_i) begin
                    state_d = dcache_ctrl_pkg::HIT;
                end else if (victim_dirty_i) begin
                    state_d = dcache_ctrl_pkg::WRITEBACK;
                end else begin
                    state_d = dcache_ctrl_pkg::REFILL;
                end
            end
            dcache_ctrl_pkg::HIT: state_d = dcache_ctrl_pkg::IDLE;
            dcache_ctrl_pkg::WRITEBACK: begin
                if (mem_done_i) begin
                    state_d = dcache_ctrl_pkg::REFILL;
                end
            end
            dcache_ctrl_pkg::REFILL: begin
                if (mem_done_i) begin
                    state_d = dcache_ctrl_pkg::LOOKUP;
                end
            end
            default: state_d = dcache_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= dcache_ctrl_pkg::IDLE;
            way_q    <= 1'b0;
            issued_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_ctrl_pkg::LOOKUP) begin
                way_q <= hit_i ? hit_way_i : victim_way_i;
            end
            if (mem_done_i) begin
                issued_q <= 1'b0;
            end else if (wb_start_o || refill_start_o) begin
                issued_q <= 1'b1;
            end
        end
    end

    assign idle_o = (state_q == dcache_ctrl_pkg::IDLE) && !start_i;
    assign busy_o = !idle_o;
    assign done_o = (state_q == dcache_ctrl_pkg::HIT);

    // victim data is read in lookup and stays put until the refill
    assign rd_way_o = (state_q == dcache_ctrl_pkg::LOOKUP) ?
                      (hit_i ? hit_way_i : victim_way_i) : way_q;

    assign wb_start_o     = (state_q == dcache_ctrl_pkg::WRITEBACK) && !issued_q;
    assign refill_start_o = (state_q == dcache_ctrl_pkg::REFILL) && !issued_q;

    assign wr_sel_refill_o = (state_q == dcache_ctrl_pkg::REFILL);
    assign fill_o          = wr_sel_refill_o && mem_done_i;
    assign wr_en_o         = fill_o || (done_o && is_write_i);
    assign wr_way_o        = way_q;
    assign mark_dirty_o    = done_o && is_write_i;
    assign touch_o         = done_o;

endmodule

/* src/dcache_data_store.sv */
`timescale 1ns/1ps

module dcache_data_store (
    input  logic                    clk,
    input  dcache_geom_pkg::index_t index_i,
    input  dcache_geom_pkg::way_t   rd_way_i,
    output dcache_geom_pkg::word_t  rd_data_o,
    input  logic                    wr_en_i,
    input  dcache_geom_pkg::way_t   wr_way_i,
    input  dcache_geom_pkg::word_t  wr_data_i,
    input  dcache_geom_pkg::mask_t  wr_mask_i
);

    dcache_geom_pkg::word_t mem_q [dcache_geom_pkg::WAYS][dcache_geom_pkg::SETS];
    dcache_geom_pkg::word_t merged;

    // keep unmasked bits of the stored word
    assign merged = (mem_q[wr_way_i][index_i] & ~wr_mask_i) | (wr_data_i & wr_mask_i);

    always_ff @(posedge clk) begin
        rd_data_o <= mem_q[rd_way_i][index_i];
        if (wr_en_i) begin
            mem_q[wr_way_i][index_i] <= merged;
        end
    end

endmodule

/* src/dcache_tag_store.sv */
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  dcache_geom_pkg::index_t index_i,
    input  dcache_geom_pkg::tag_t   tag_i,
    output logic                    hit_o,
    output dcache_geom_pkg::way_t   hit_way_o,
    output dcache_geom_pkg::way_t   victim_way_o,
    output logic                    victim_dirty_o,
    output dcache_geom_pkg::tag_t   victim_tag_o,
    input  logic                    fill_i,
    input  dcache_geom_pkg::way_t   fill_way_i,
    input  logic                    mark_dirty_i,
    input  logic                    touch_i,
    input  dcache_geom_pkg::way_t   touch_way_i
);

    dcache_geom_pkg::tag_t tag_q [dcache_geom_pkg::WAYS][dcache_geom_pkg::SETS];
    logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] valid_q;
    logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] dirty_q;
    // per set, the least recently used way
    logic [dcache_geom_pkg::SETS-1:0] lru_q;

    logic [dcache_geom_pkg::WAYS-1:0] match;
    dcache_geom_pkg::way_t            victim;

    always_comb begin
        for (int w = 0; w < dcache_geom_pkg::WAYS; w++) begin
            match[w] = valid_q[index_i][w] && (tag_q[w][index_i] == tag_i);
        end
    end

    assign hit_o     = |match;
    assign hit_way_o = match[1];

    // invalid way first, way 0 before way 1, else lru
    always_comb begin
        if (!valid_q[index_i][0]) begin
            victim = 1'b0;
        end else if (!valid_q[index_i][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[index_i];
        end
    end

    assign victim_way_o   = victim;
    assign victim_dirty_o = valid_q[index_i][victim] & dirty_q[index_i][victim];
    assign victim_tag_o   = tag_q[victim][index_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index_i][fill_way_i] <= 1'b1;
                dirty_q[index_i][fill_way_i] <= 1'b0;
                lru_q[index_i]               <= ~fill_way_i;
            end
            if (mark_dirty_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_way_i][index_i] <= tag_i;
        end
    end

endmodule

/* src/dcache_req_port.sv */
`timescale 1ns/1ps

module dcache_req_port (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_read_i,
    input  logic                    req_write_i,
    input  dcache_geom_pkg::addr_t  req_addr_i,
    input  dcache_geom_pkg::word_t  req_wdata_i,
    input  dcache_geom_pkg::strb_t  req_strb_i,
    input  logic                    idle_i,
    output logic                    start_o,
    output logic                    is_write_o,
    output dcache_geom_pkg::tag_t   tag_o,
    output dcache_geom_pkg::index_t index_o,
    output dcache_geom_pkg::word_t  wdata_o,
    output dcache_geom_pkg::mask_t  wmask_o
);

    logic                   accept;
    dcache_geom_pkg::mask_t wmask_d;

    assign accept = (req_read_i | req_write_i) & idle_i;

    // byte strobes to bit mask
    always_comb begin
        for (int i = 0; i < dcache_geom_pkg::STRB_W; i++) begin
            wmask_d[i*8 +: 8] = {8{req_strb_i[i]}};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            start_o    <= 1'b0;
            is_write_o <= 1'b0;
        end else begin
            start_o <= accept;
            if (accept) begin
                is_write_o <= req_write_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_o   <= req_addr_i[dcache_geom_pkg::ADDR_W-1 -: dcache_geom_pkg::TAG_W];
            index_o <= req_addr_i[dcache_geom_pkg::OFFSET_W +: dcache_geom_pkg::INDEX_W];
            wdata_o <= req_wdata_i;
            wmask_o <= wmask_d;
        end
    end

endmodule

/* src/dcache_ctrl_pkg.sv */
package dcache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

    // operation on the memory port
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_WRITEBACK,
        MEM_REFILL
    } mem_op_t;

endpackage

/* src/dcache_geom_pkg.sv */
package dcache_geom_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 64;
    localparam int STRB_W = 8;
    localparam int TAG_W = 23;
    localparam int INDEX_W = 6;
    localparam int SETS = 64;
    localparam int WAYS = 2;
    localparam int OFFSET_W = 3;

    // address is {tag, index, byte offset}
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    // one bit per data bit
    typedef logic [WORD_W-1:0] mask_t;

    typedef logic way_t;

endpackage
